// ==== rtl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;   // Shift amount taken from operand 2

    // Major opcodes in instr[6:0]
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_I_ALU  = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_R_ALU  = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // Minor opcode for register and immediate ALU ops
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    // Branch conditions share the funct3 bits
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;   // SUB and SRA

    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = FUNCT7_ALT
    } funct7_e;

endpackage

`default_nettype wire

// ==== rtl/core_ctrl_pkg.sv ====
`default_nettype none

package core_ctrl_pkg;

    localparam int DRAM_ADDR_W = 8;   // 256 words

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_src_e;
    typedef enum logic [1:0] {OP2_RS2, OP2_IMM, OP2_FOUR} op2_src_e;
    typedef enum logic {PC_BASE_PC, PC_BASE_RS1} pc_op1_src_e;

    // Branch rules test the ALU result against zero
    typedef enum logic [1:0] {NPC_SEQ, NPC_ALWAYS, NPC_IF_ZERO, NPC_IF_NOT_ZERO} next_pc_e;

    typedef enum logic {WB_ALU, WB_RAM} wb_src_e;

    typedef struct packed {
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
        logic [rv_isa_pkg::XLEN-1:0]       imm;
        alu_op_e                           alu_op;
        op1_src_e                          op1_src;
        op2_src_e                          op2_src;
        pc_op1_src_e                       pc_op1_src;
        next_pc_e                          next_pc;
        wb_src_e                           wb_src;
        logic                              reg_we;
        logic                              ram_we;
    } ctrl_t;

    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0]       pc;
        logic                              rd_we;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
        logic [rv_isa_pkg::XLEN-1:0]       rd_data;
    } retire_t;

endpackage

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  wire logic [rv_isa_pkg::XLEN-1:0] instr_i,
    output core_ctrl_pkg::ctrl_t             ctrl_o
);

    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    opcode_e         opcode;
    funct3_e         funct3;
    funct7_e         funct7;
    logic            shift_alt;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    // Same funct3 mapping for register and immediate forms
    function automatic alu_op_e alu_sel(input funct3_e f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = funct3_e'(instr_i[14:12]);
    assign funct7 = funct7_e'(instr_i[31:25]);

    // Only SRAI has an alternate immediate form so ADDI never becomes SUB
    assign shift_alt = (funct3 == F3_SRL_SRA) && (funct7 == F7_ALT);

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        // No-op defaults also cover unknown opcodes
        ctrl_o.rs1        = instr_i[19:15];
        ctrl_o.rs2        = instr_i[24:20];
        ctrl_o.rd         = instr_i[11:7];
        ctrl_o.imm        = '0;
        ctrl_o.alu_op     = ALU_ADD;
        ctrl_o.op1_src    = OP1_RS1;
        ctrl_o.op2_src    = OP2_IMM;
        ctrl_o.pc_op1_src = PC_BASE_PC;
        ctrl_o.next_pc    = NPC_SEQ;
        ctrl_o.wb_src     = WB_ALU;
        ctrl_o.reg_we     = 1'b0;
        ctrl_o.ram_we     = 1'b0;

        case (opcode)
            OP_R_ALU: begin
                ctrl_o.op2_src = OP2_RS2;
                ctrl_o.alu_op  = alu_sel(funct3, funct7 == F7_ALT);
                ctrl_o.reg_we  = 1'b1;
            end
            OP_I_ALU: begin
                ctrl_o.imm    = imm_i;   // Shifts only look at the low 5 bits
                ctrl_o.alu_op = alu_sel(funct3, shift_alt);
                ctrl_o.reg_we = 1'b1;
            end
            OP_LOAD: begin
                ctrl_o.imm    = imm_i;
                ctrl_o.wb_src = WB_RAM;
                ctrl_o.reg_we = 1'b1;
            end
            OP_STORE: begin
                ctrl_o.imm    = imm_s;
                ctrl_o.ram_we = 1'b1;
            end
            OP_BRANCH: begin
                ctrl_o.imm     = imm_b;
                ctrl_o.op2_src = OP2_RS2;
                case (instr_i[14:12])
                    FUNCT3_BEQ: begin
                        ctrl_o.alu_op  = ALU_SUB;
                        ctrl_o.next_pc = NPC_IF_ZERO;
                    end
                    FUNCT3_BNE: begin
                        ctrl_o.alu_op  = ALU_SUB;
                        ctrl_o.next_pc = NPC_IF_NOT_ZERO;
                    end
                    FUNCT3_BLT: begin
                        ctrl_o.alu_op  = ALU_SLT;
                        ctrl_o.next_pc = NPC_IF_NOT_ZERO;
                    end
                    FUNCT3_BGE: begin
                        ctrl_o.alu_op  = ALU_SLT;
                        ctrl_o.next_pc = NPC_IF_ZERO;
                    end
                    FUNCT3_BLTU: begin
                        ctrl_o.alu_op  = ALU_SLTU;
                        ctrl_o.next_pc = NPC_IF_NOT_ZERO;
                    end
                    FUNCT3_BGEU: begin
                        ctrl_o.alu_op  = ALU_SLTU;
                        ctrl_o.next_pc = NPC_IF_ZERO;
                    end
                    default: ctrl_o.next_pc = NPC_SEQ;   // Reserved encodings act as a no-op
                endcase
            end
            OP_JAL: begin
                ctrl_o.imm     = imm_j;
                ctrl_o.op1_src = OP1_PC;
                ctrl_o.op2_src = OP2_FOUR;
                ctrl_o.next_pc = NPC_ALWAYS;
                ctrl_o.reg_we  = 1'b1;
            end
            OP_JALR: begin
                ctrl_o.imm        = imm_i;
                ctrl_o.op1_src    = OP1_PC;
                ctrl_o.op2_src    = OP2_FOUR;
                ctrl_o.pc_op1_src = PC_BASE_RS1;
                ctrl_o.next_pc    = NPC_ALWAYS;
                ctrl_o.reg_we     = 1'b1;
            end
            OP_LUI: begin
                ctrl_o.imm     = imm_u;
                ctrl_o.op1_src = OP1_ZERO;
                ctrl_o.reg_we  = 1'b1;
            end
            OP_AUIPC: begin
                ctrl_o.imm     = imm_u;
                ctrl_o.op1_src = OP1_PC;
                ctrl_o.reg_we  = 1'b1;
            end
            default: ctrl_o.reg_we = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,
    input  wire logic                        we_i,
    input  wire core_ctrl_pkg::ctrl_t        ctrl_i,
    input  wire logic [rv_isa_pkg::XLEN-1:0] alu_result_i,
    input  wire logic [rv_isa_pkg::XLEN-1:0] load_data_i,
    output logic [rv_isa_pkg::XLEN-1:0]      rs1_data_o,
    output logic [rv_isa_pkg::XLEN-1:0]      rs2_data_o,
    output logic [rv_isa_pkg::XLEN-1:0]      rd_data_o
);

    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [XLEN-1:0] regs [1:(1 << REG_ADDR_W)-1];   // x0 has no storage

    assign rs1_data_o = (ctrl_i.rs1 == '0) ? '0 : regs[ctrl_i.rs1];
    assign rs2_data_o = (ctrl_i.rs2 == '0) ? '0 : regs[ctrl_i.rs2];

    // Writeback mux
    assign rd_data_o = (ctrl_i.wb_src == WB_RAM) ? load_data_i : alu_result_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < (1 << REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && ctrl_i.reg_we && ctrl_i.rd != '0) begin
            regs[ctrl_i.rd] <= rd_data_o;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
    input  wire core_ctrl_pkg::ctrl_t        ctrl_i,
    input  wire logic [rv_isa_pkg::XLEN-1:0] pc_i,
    input  wire logic [rv_isa_pkg::XLEN-1:0] rs1_data_i,
    input  wire logic [rv_isa_pkg::XLEN-1:0] rs2_data_i,
    output logic [rv_isa_pkg::XLEN-1:0]      alu_result_o
);

    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [XLEN-1:0]    op1;
    logic [XLEN-1:0]    op2;
    logic [SHAMT_W-1:0] shamt;

    always_comb begin
        case (ctrl_i.op1_src)
            OP1_PC:   op1 = pc_i;
            OP1_ZERO: op1 = '0;   // LUI
            default:  op1 = rs1_data_i;
        endcase

        case (ctrl_i.op2_src)
            OP2_IMM:  op2 = ctrl_i.imm;
            OP2_FOUR: op2 = XLEN'(4);   // Link address for JAL and JALR
            default:  op2 = rs2_data_i;
        endcase
    end

    assign shamt = op2[SHAMT_W-1:0];

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD:  alu_result_o = op1 + op2;
            ALU_SUB:  alu_result_o = op1 - op2;
            ALU_XOR:  alu_result_o = op1 ^ op2;
            ALU_OR:   alu_result_o = op1 | op2;
            ALU_AND:  alu_result_o = op1 & op2;
            ALU_SLL:  alu_result_o = op1 << shamt;
            ALU_SRL:  alu_result_o = op1 >> shamt;
            ALU_SRA:  alu_result_o = $signed(op1) >>> shamt;
            ALU_SLT:  alu_result_o = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_SLTU: alu_result_o = {{(XLEN-1){1'b0}}, op1 < op2};
            default:  alu_result_o = op1 + op2;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/next_pc_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module next_pc_unit (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,
    input  wire logic                        advance_i,
    input  wire core_ctrl_pkg::ctrl_t        ctrl_i,
    input  wire logic [rv_isa_pkg::XLEN-1:0] rs1_data_i,
    input  wire logic [rv_isa_pkg::XLEN-1:0] alu_result_i,
    output logic [rv_isa_pkg::XLEN-1:0]      pc_o
);

    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [XLEN-1:0] base;
    logic [XLEN-1:0] target;
    logic            alu_zero;
    logic            taken;

    assign base = (ctrl_i.pc_op1_src == PC_BASE_RS1) ? rs1_data_i : pc_o;

    always_comb begin
        target = base + ctrl_i.imm;
        // JALR target drops bit 0
        if (ctrl_i.pc_op1_src == PC_BASE_RS1) begin
            target[0] = 1'b0;
        end
    end

    assign alu_zero = (alu_result_i == '0);

    always_comb begin
        case (ctrl_i.next_pc)
            NPC_ALWAYS:      taken = 1'b1;
            NPC_IF_ZERO:     taken = alu_zero;
            NPC_IF_NOT_ZERO: taken = !alu_zero;
            default:         taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_o <= '0;
        end else if (advance_i) begin
            pc_o <= taken ? target : pc_o + XLEN'(4);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_ram (
    input  wire logic                                clk_i,
    input  wire logic                                we_i,
    input  wire logic [core_ctrl_pkg::DRAM_ADDR_W-1:0] addr_i,
    input  wire logic [rv_isa_pkg::XLEN-1:0]         wdata_i,
    output logic [rv_isa_pkg::XLEN-1:0]              rdata_o
);

    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [XLEN-1:0] mem [0:(1 << DRAM_ADDR_W)-1];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    assign rdata_o = mem[addr_i];   // Read in the same cycle for LW

endmodule

`default_nettype wire

// ==== rtl/rv_core_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_top (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,
    input  wire logic                        instr_valid_i,
    input  wire logic [rv_isa_pkg::XLEN-1:0] instr_i,
    output logic [rv_isa_pkg::XLEN-1:0]      pc_o,
    output core_ctrl_pkg::retire_t           retire_o
);

    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    ctrl_t           ctrl;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] rd_data;

    instr_decoder decoder_i (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    reg_file reg_file_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .we_i         (instr_valid_i),
        .ctrl_i       (ctrl),
        .alu_result_i (alu_result),
        .load_data_i  (load_data),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .rd_data_o    (rd_data)
    );

    exec_unit exec_unit_i (
        .ctrl_i       (ctrl),
        .pc_i         (pc_o),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .alu_result_o (alu_result)
    );

    next_pc_unit next_pc_unit_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .advance_i    (instr_valid_i),   // Low level stalls the core
        .ctrl_i       (ctrl),
        .rs1_data_i   (rs1_data),
        .alu_result_i (alu_result),
        .pc_o         (pc_o)
    );

    // Word address without the byte offset bits
    data_ram data_ram_i (
        .clk_i   (clk_i),
        .we_i    (ctrl.ram_we & instr_valid_i),
        .addr_i  (alu_result[DRAM_ADDR_W+1:2]),
        .wdata_i (rs2_data),
        .rdata_o (load_data)
    );

    assign retire_o.pc      = pc_o;
    assign retire_o.rd_we   = ctrl.reg_we & instr_valid_i;
    assign retire_o.rd      = ctrl.rd;
    assign retire_o.rd_data = rd_data;

endmodule

`default_nettype wire

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;

    import core_ctrl_pkg::*;

    localparam int SETTLE     = 20;
    localparam int EDGE_LIMIT = 4;       // Clock transitions allowed per edge wait
    localparam int RUN_LIMIT  = 20000;

    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    typedef struct packed {
        logic [31:0] instr;
        logic        valid;
        retire_t     exp;
    } step_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    retire_t     retire;

    step_t       steps[$];
    string       names[$];
    logic [31:0] xreg [0:31];            // Reference register model
    logic [31:0] model_pc;
    integer      seed;
    int          errors;
    int          checks;
    logic        timed_out;

    rv_core_top dut_i (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_o          (pc),
        .retire_o      (retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(RUN_LIMIT);
        $display("Simulation ran past its time limit");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic push_entry(input string name, input logic [31:0] word, input logic valid,
                              input logic rd_we, input logic [4:0] rd,
                              input logic [31:0] rd_data, input logic [31:0] next_pc);
        step_t s;
        s.instr       = word;
        s.valid       = valid;
        s.exp.pc      = model_pc;
        s.exp.rd_we   = rd_we;
        s.exp.rd      = rd;
        s.exp.rd_data = rd_data;
        steps.push_back(s);
        names.push_back(name);
        if (valid) begin
            model_pc = next_pc;
            if (rd_we && rd != 5'd0) begin
                xreg[rd] = rd_data;
            end
        end
    endtask

    task automatic reg_write_op(input string name, input logic [31:0] word,
                                input logic [4:0] rd, input logic [31:0] data);
        push_entry(name, word, 1'b1, 1'b1, rd, data, model_pc + 32'd4);
    endtask

    task automatic branch_op(input string name, input logic [31:0] word, input logic taken,
                             input logic [12:0] off);
        push_entry(name, word, 1'b1, 1'b0, 5'd0, 32'd0,
                   taken ? model_pc + {{19{off[12]}}, off} : model_pc + 32'd4);
    endtask

    task automatic build_program();
        logic [31:0] rnd;
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        for (int r = 0; r < 32; r++) begin
            xreg[r] = '0;
        end
        model_pc = '0;
        rnd   = $random(seed);
        imm_a = {1'b1, rnd[10:0]};       // Negative
        rnd   = $random(seed);
        imm_b = {1'b0, rnd[10:0]};       // Non-negative
        rnd   = $random(seed);

        reg_write_op("addi_x1", i_type(imm_a, 5'd0, 3'b000, 5'd1, OPC_IMM), 5'd1, sext12(imm_a));
        reg_write_op("addi_x2", i_type(imm_b, 5'd0, 3'b000, 5'd2, OPC_IMM), 5'd2, sext12(imm_b));
        reg_write_op("addi_x0", i_type(12'd5, 5'd0, 3'b000, 5'd0, OPC_IMM), 5'd0, 32'd5);
        reg_write_op("add_x0_src", r_type(7'd0, 5'd1, 5'd0, 3'b000, 5'd3), 5'd3, xreg[0] + xreg[1]);
        reg_write_op("add", r_type(7'd0, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, xreg[1] + xreg[2]);
        reg_write_op("sub", r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd5), 5'd5, xreg[1] - xreg[2]);
        reg_write_op("xor", r_type(7'd0, 5'd2, 5'd1, 3'b100, 5'd6), 5'd6, xreg[1] ^ xreg[2]);
        reg_write_op("or", r_type(7'd0, 5'd2, 5'd1, 3'b110, 5'd7), 5'd7, xreg[1] | xreg[2]);
        reg_write_op("and", r_type(7'd0, 5'd2, 5'd1, 3'b111, 5'd8), 5'd8, xreg[1] & xreg[2]);
        // Odd shift amount so every shift moves the bits
        reg_write_op("addi_shamt", i_type({7'd0, rnd[4:1], 1'b1}, 5'd0, 3'b000, 5'd9, OPC_IMM),
                     5'd9, {27'd0, rnd[4:1], 1'b1});
        reg_write_op("sll", r_type(7'd0, 5'd9, 5'd1, 3'b001, 5'd10), 5'd10,
                     xreg[1] << xreg[9][4:0]);
        reg_write_op("srl", r_type(7'd0, 5'd9, 5'd1, 3'b101, 5'd11), 5'd11,
                     xreg[1] >> xreg[9][4:0]);
        reg_write_op("sra", r_type(7'h20, 5'd9, 5'd1, 3'b101, 5'd12), 5'd12,
                     $signed(xreg[1]) >>> xreg[9][4:0]);
        reg_write_op("srai", i_type({7'h20, 5'd7}, 5'd1, 3'b101, 5'd13, OPC_IMM), 5'd13,
                     $signed(xreg[1]) >>> 7);
        // Signed and unsigned compares disagree for x2 against a negative immediate
        reg_write_op("slti", i_type(12'hfff, 5'd2, 3'b010, 5'd14, OPC_IMM), 5'd14,
                     {31'd0, $signed(xreg[2]) < -32'sd1});
        reg_write_op("sltiu", i_type(12'h800, 5'd2, 3'b011, 5'd15, OPC_IMM), 5'd15,
                     {31'd0, xreg[2] < 32'hfffff800});
        reg_write_op("slt", r_type(7'd0, 5'd2, 5'd1, 3'b010, 5'd16), 5'd16,
                     {31'd0, $signed(xreg[1]) < $signed(xreg[2])});
        reg_write_op("lui", {20'h12345, 5'd17, OPC_LUI}, 5'd17, 32'h12345000);
        reg_write_op("auipc", {20'h00001, 5'd18, OPC_AUIPC}, 5'd18, model_pc + 32'h1000);
        push_entry("sw", {7'd2, 5'd4, 5'd0, 3'b010, 5'd0, 7'b0100011}, 1'b1, 1'b0, 5'd0, 32'd0,
                   model_pc + 32'd4);
        reg_write_op("lw", i_type(12'h040, 5'd0, 3'b010, 5'd19, OPC_LOAD), 5'd19, xreg[4]);

        // x1 is negative, x2 is non-negative and x3 equals x1
        branch_op("beq_taken", b_type(13'd8, 5'd3, 5'd1, 3'b000), xreg[1] == xreg[3], 13'd8);
        branch_op("beq_not", b_type(13'd8, 5'd2, 5'd1, 3'b000), xreg[1] == xreg[2], 13'd8);
        branch_op("bne_taken", b_type(13'd12, 5'd2, 5'd1, 3'b001), xreg[1] != xreg[2], 13'd12);
        branch_op("bne_not", b_type(13'd12, 5'd3, 5'd1, 3'b001), xreg[1] != xreg[3], 13'd12);
        branch_op("blt_taken", b_type(13'h1ff8, 5'd2, 5'd1, 3'b100),
                  $signed(xreg[1]) < $signed(xreg[2]), 13'h1ff8);
        branch_op("blt_not", b_type(13'd8, 5'd1, 5'd2, 3'b100),
                  $signed(xreg[2]) < $signed(xreg[1]), 13'd8);
        branch_op("bge_taken", b_type(13'd16, 5'd1, 5'd2, 3'b101),
                  $signed(xreg[2]) >= $signed(xreg[1]), 13'd16);
        branch_op("bge_not", b_type(13'd16, 5'd2, 5'd1, 3'b101),
                  $signed(xreg[1]) >= $signed(xreg[2]), 13'd16);
        branch_op("bltu_taken", b_type(13'd20, 5'd1, 5'd2, 3'b110), xreg[2] < xreg[1], 13'd20);
        branch_op("bltu_not", b_type(13'd20, 5'd2, 5'd1, 3'b110), xreg[1] < xreg[2], 13'd20);
        branch_op("bgeu_taken", b_type(13'd24, 5'd2, 5'd1, 3'b111), xreg[1] >= xreg[2], 13'd24);
        branch_op("bgeu_not", b_type(13'd24, 5'd1, 5'd2, 3'b111), xreg[2] >= xreg[1], 13'd24);

        reg_write_op("addi_x21", i_type(12'h101, 5'd0, 3'b000, 5'd21, OPC_IMM), 5'd21, 32'h101);
        push_entry("jal", j_type(21'd16, 5'd20), 1'b1, 1'b1, 5'd20, model_pc + 32'd4,
                   model_pc + 32'd16);
        push_entry("jalr", i_type(12'h020, 5'd21, 3'b000, 5'd22, OPC_JALR), 1'b1, 1'b1, 5'd22,
                   model_pc + 32'd4, (xreg[21] + 32'h20) & ~32'd1);
        push_entry("stall", i_type(12'd99, 5'd0, 3'b000, 5'd3, OPC_IMM), 1'b0, 1'b0, 5'd0,
                   32'd0, model_pc);
        reg_write_op("after_stall", r_type(7'd0, 5'd0, 5'd3, 3'b000, 5'd23), 5'd23, xreg[3]);
    endtask

    task automatic wait_rising_edge();
        int transitions;
        transitions = 0;
        do begin
            @(clk);
            transitions++;
        end while (clk !== 1'b1 && transitions < EDGE_LIMIT);
        if (clk !== 1'b1) begin
            $display("Timeout while waiting for a rising clock edge");
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s %s expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_step(input int idx);
        step_t s;
        string n;
        s = steps[idx];
        n = names[idx];
        check_value(n, "pc_o", s.exp.pc, pc);
        check_value(n, "retire pc", s.exp.pc, retire.pc);
        check_value(n, "rd_we", {31'd0, s.exp.rd_we}, {31'd0, retire.rd_we});
        if (s.exp.rd_we) begin
            check_value(n, "rd", {27'd0, s.exp.rd}, {27'd0, retire.rd});
            check_value(n, "rd_data", s.exp.rd_data, retire.rd_data);
        end
    endtask

    initial begin
        int i;
        int n;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'h00000013;     // ADDI x0, x0, 0
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        seed        = 32'h0d03fc6a;
        build_program();

        for (n = 0; n < 5 && !timed_out; n++) begin
            wait_rising_edge();
        end
        rst_n <= 1'b1;
        #(SETTLE);
        check_value("reset", "pc_o", 32'd0, pc);
        check_value("reset", "rd_we", 32'd0, {31'd0, retire.rd_we});

        for (i = 0; i < steps.size() && !timed_out; i++) begin
            wait_rising_edge();
            if (!timed_out) begin
                instr       <= steps[i].instr;
                instr_valid <= steps[i].valid;
                #(SETTLE);
                check_step(i);
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/rv_isa_pkg.sv
rtl/core_ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/next_pc_unit.sv
rtl/data_ram.sv
rtl/rv_core_top.sv
verification/rv_core_tb.sv

// ==== build.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns --top-module rv_core_tb \
    -f build.f -o rv_core_sim

out=$(./obj_dir/rv_core_sim)
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi
